// ==== rtl/uart_mem_pkg.sv ====
`default_nettype none

package uart_mem_pkg;

    localparam int WORD_W         = 32;
    localparam int BYTE_W         = 8;
    localparam int BYTES_PER_WORD = 4;
    localparam int RAM_DEPTH      = 16;
    localparam int ADDR_W         = 4;
    localparam int CLKS_PER_BIT   = 8;
    localparam int SCAN_CLKS      = 16;
    localparam int DIGITS         = 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // common anode, bit 7 is the dot and stays dark
    function automatic logic [7:0] hex_to_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0: hex_to_seg = 8'hc0;
            4'h1: hex_to_seg = 8'hf9;
            4'h2: hex_to_seg = 8'ha4;
            4'h3: hex_to_seg = 8'hb0;
            4'h4: hex_to_seg = 8'h99;
            4'h5: hex_to_seg = 8'h92;
            4'h6: hex_to_seg = 8'h82;
            4'h7: hex_to_seg = 8'hf8;
            4'h8: hex_to_seg = 8'h80;
            4'h9: hex_to_seg = 8'h90;
            4'ha: hex_to_seg = 8'h88;
            4'hb: hex_to_seg = 8'h83;
            4'hc: hex_to_seg = 8'hc6;
            4'hd: hex_to_seg = 8'ha1;
            4'he: hex_to_seg = 8'h86;
            default: hex_to_seg = 8'h8e;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== rtl/mem_port_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface mem_port_if import uart_mem_pkg::*; ();

    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
    logic  gnt;
    word_t rdata;

    modport requester (output req, we, addr, wdata, input gnt, rdata);

    modport arbiter (input req, we, addr, wdata, output gnt, rdata);

endinterface

`default_nettype wire

// ==== rtl/uart_byte_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_byte_rx import uart_mem_pkg::*; (
    input  wire logic              clk_raw,
    input  wire logic              rst_n,
    input  wire logic              rx,
    output logic [BYTE_W-1:0]      byte_data,
    output logic                   byte_valid
);

    typedef logic [$clog2(CLKS_PER_BIT)-1:0] bit_cnt_t;
    typedef logic [$clog2(BYTE_W)-1:0] bit_idx_t;
    typedef enum logic [2:0] {S_IDLE, S_START, S_DATA, S_STOP, S_TAIL} rx_state_t;

    rx_state_t state;
    bit_cnt_t  bit_cnt;
    bit_idx_t  bit_idx;
    logic      rx_meta;
    logic      rx_sync;
    logic      stop_ok;

    always_ff @(posedge clk_raw or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk_raw or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            stop_ok    <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            bit_cnt    <= bit_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    bit_cnt <= '0;
                    if (!rx_sync)
                        state <= S_START;
                end
                // recheck the start bit at its middle
                S_START: begin
                    if (bit_cnt == bit_cnt_t'(CLKS_PER_BIT / 2 - 1)) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? S_IDLE : S_DATA;
                    end
                end
                S_DATA: begin
                    if (bit_cnt == bit_cnt_t'(CLKS_PER_BIT - 1)) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == bit_idx_t'(BYTE_W - 1))
                            state <= S_STOP;
                    end
                end
                S_STOP: begin
                    if (bit_cnt == bit_cnt_t'(CLKS_PER_BIT - 1)) begin
                        stop_ok <= rx_sync;
                        bit_cnt <= '0;
                        state   <= S_TAIL;
                    end
                end
                // half a bit past the stop sample
                default: begin
                    if (bit_cnt == bit_cnt_t'(CLKS_PER_BIT / 2 - 1)) begin
                        byte_valid <= stop_ok;
                        state      <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk_raw) begin
        if (state == S_DATA && bit_cnt == bit_cnt_t'(CLKS_PER_BIT - 1))
            byte_data <= {rx_sync, byte_data[BYTE_W-1:1]};
    end

endmodule

`default_nettype wire

// ==== rtl/word_loader.sv ====
`timescale 1ns/1ns
`default_nettype none

module word_loader import uart_mem_pkg::*; (
    input  wire logic              clk_raw,
    input  wire logic              rst_n,
    input  wire logic [BYTE_W-1:0] byte_data,
    input  wire logic              byte_valid,
    mem_port_if.requester          mem,
    output logic                   written
);

    typedef logic [$clog2(BYTES_PER_WORD)-1:0] byte_cnt_t;

    byte_cnt_t byte_cnt;
    addr_t     wr_addr;
    word_t     word_reg;
    logic      wr_req;

    // new bytes enter at the top so the first one ends up lowest
    always_ff @(posedge clk_raw) begin
        if (byte_valid)
            word_reg <= {byte_data, word_reg[WORD_W-1:BYTE_W]};
    end

    always_ff @(posedge clk_raw or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= '0;
            wr_addr  <= '0;
            wr_req   <= 1'b0;
        end else begin
            if (byte_valid) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == byte_cnt_t'(BYTES_PER_WORD - 1))
                    wr_req <= 1'b1;
            end
            if (wr_req && mem.gnt) begin
                wr_req  <= 1'b0;
                wr_addr <= (wr_addr == addr_t'(RAM_DEPTH - 1)) ? '0 : wr_addr + 1'b1;
            end
        end
    end

    assign mem.req   = wr_req;
    assign mem.we    = 1'b1;
    assign mem.addr  = wr_addr;
    assign mem.wdata = word_reg;

    // high on the granted edge
    assign written = wr_req & mem.gnt;

endmodule

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter import uart_mem_pkg::*; (
    input  wire logic      clk_raw,
    input  wire logic      rst_n,
    mem_port_if.arbiter    loader_port,
    mem_port_if.arbiter    display_port,
    output logic           ram_we,
    output addr_t          ram_addr,
    output word_t          ram_wdata,
    input  wire word_t     ram_rdata
);

    logic loader_gnt;
    logic display_gnt;
    logic loader_owns_rd;
    logic display_owns_rd;

    // fixed priority, loader first
    assign loader_gnt  = loader_port.req;
    assign display_gnt = display_port.req & ~loader_port.req;

    assign loader_port.gnt  = loader_gnt;
    assign display_port.gnt = display_gnt;

    assign ram_we    = loader_gnt ? loader_port.we : (display_gnt & display_port.we);
    assign ram_addr  = loader_gnt ? loader_port.addr : display_port.addr;
    assign ram_wdata = loader_gnt ? loader_port.wdata : display_port.wdata;

    // remember who owns the read data coming out next cycle
    always_ff @(posedge clk_raw or negedge rst_n) begin
        if (!rst_n) begin
            loader_owns_rd  <= 1'b0;
            display_owns_rd <= 1'b0;
        end else begin
            loader_owns_rd  <= loader_gnt;
            display_owns_rd <= display_gnt;
        end
    end

    assign loader_port.rdata  = loader_owns_rd ? ram_rdata : '0;
    assign display_port.rdata = display_owns_rd ? ram_rdata : '0;

endmodule

`default_nettype wire

// ==== rtl/data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_ram import uart_mem_pkg::*; (
    input  wire logic  clk_raw,
    input  wire logic  we,
    input  wire addr_t addr,
    input  wire word_t wdata,
    output word_t      rdata
);

    word_t mem [RAM_DEPTH];

    always_ff @(posedge clk_raw) begin
        if (we)
            mem[addr] <= wdata;
    end

    // old contents on a same-cycle write
    always_ff @(posedge clk_raw) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// ==== rtl/hex_display.sv ====
`timescale 1ns/1ns
`default_nettype none

module hex_display import uart_mem_pkg::*; (
    input  wire logic  clk_raw,
    input  wire logic  rst_n,
    input  wire addr_t sel_addr,
    mem_port_if.requester mem,
    output logic [7:0] seg_tube,
    output logic [7:0] seg_enable
);

    typedef logic [$clog2(SCAN_CLKS)-1:0] scan_cnt_t;
    typedef logic [$clog2(DIGITS)-1:0] digit_t;
    typedef enum logic [1:0] {S_ADDR, S_REQ, S_DATA} rd_state_t;

    rd_state_t rd_state;
    addr_t     rd_addr;
    word_t     shown_word;
    scan_cnt_t scan_cnt;
    digit_t    digit;
    logic [3:0] nibble;

    always_ff @(posedge clk_raw or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= S_ADDR;
        end else begin
            case (rd_state)
                S_ADDR: rd_state <= S_REQ;
                S_REQ: begin
                    if (mem.gnt)
                        rd_state <= S_DATA;
                end
                default: rd_state <= S_ADDR;
            endcase
        end
    end

    // address is frozen while the request is pending
    always_ff @(posedge clk_raw) begin
        if (rd_state == S_ADDR)
            rd_addr <= sel_addr;
        if (rd_state == S_DATA)
            shown_word <= mem.rdata;
    end

    assign mem.req   = (rd_state == S_REQ);
    assign mem.we    = 1'b0;
    assign mem.addr  = rd_addr;
    assign mem.wdata = '0;

    always_ff @(posedge clk_raw or negedge rst_n) begin
        if (!rst_n) begin
            scan_cnt <= '0;
            digit    <= '0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
            if (scan_cnt == scan_cnt_t'(SCAN_CLKS - 1)) begin
                scan_cnt <= '0;
                digit    <= digit + 1'b1;
            end
        end
    end

    assign nibble     = shown_word[{digit, 2'b00} +: 4];
    assign seg_tube   = hex_to_seg(nibble);
    assign seg_enable = ~(8'(1) << digit);

endmodule

`default_nettype wire

// ==== rtl/uart_mem_display.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_mem_display import uart_mem_pkg::*; (
    input  wire logic       clk_raw,
    input  wire logic       rst_n,
    input  wire logic       uart_rx,
    input  wire logic [7:0] switch_map,
    output logic [7:0]      seg_tube,
    output logic [7:0]      seg_enable,
    output logic            uart_in_progress
);

    logic [BYTE_W-1:0] rx_byte_data;
    logic              rx_byte_valid;
    logic              loader_written;
    logic              ram_we;
    addr_t             ram_addr;
    word_t             ram_wdata;
    word_t             ram_rdata;

    mem_port_if loader_mem ();
    mem_port_if display_mem ();

    uart_byte_rx uart_byte_rx_i (
        .clk_raw    (clk_raw),
        .rst_n      (rst_n),
        .rx         (uart_rx),
        .byte_data  (rx_byte_data),
        .byte_valid (rx_byte_valid)
    );

    word_loader word_loader_i (
        .clk_raw    (clk_raw),
        .rst_n      (rst_n),
        .byte_data  (rx_byte_data),
        .byte_valid (rx_byte_valid),
        .mem        (loader_mem.requester),
        .written    (loader_written)
    );

    mem_arbiter mem_arbiter_i (
        .clk_raw      (clk_raw),
        .rst_n        (rst_n),
        .loader_port  (loader_mem.arbiter),
        .display_port (display_mem.arbiter),
        .ram_we       (ram_we),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .ram_rdata    (ram_rdata)
    );

    data_ram data_ram_i (
        .clk_raw (clk_raw),
        .we      (ram_we),
        .addr    (ram_addr),
        .wdata   (ram_wdata),
        .rdata   (ram_rdata)
    );

    hex_display hex_display_i (
        .clk_raw    (clk_raw),
        .rst_n      (rst_n),
        .sel_addr   (switch_map[ADDR_W-1:0]),
        .mem        (display_mem.requester),
        .seg_tube   (seg_tube),
        .seg_enable (seg_enable)
    );

    // led strobe per stored word
    always_ff @(posedge clk_raw or negedge rst_n) begin
        if (!rst_n)
            uart_in_progress <= 1'b0;
        else
            uart_in_progress <= loader_written;
    end

endmodule

`default_nettype wire

// ==== tb/tb_uart_mem_display.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_uart_mem_display import uart_mem_pkg::*; ();

    // common anode codes with segments g to a in bits 6 to 0 and the dot dark
    localparam logic [7:0] SEG_CODES [16] = '{8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92,
        8'h82, 8'hf8, 8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e};

    logic       clk_raw = 1'b0;
    logic       rst_n = 1'b0;
    logic       uart_rx = 1'b1;
    logic [7:0] switch_map = 8'h00;
    logic [7:0] seg_tube;
    logic [7:0] seg_enable;
    logic       uart_in_progress;

    word_t      shown = '0;
    logic [7:0] prev_enable = 8'hfe;
    logic       prev_pulse = 1'b0;
    int         pulse_count = 0;

    uart_mem_display uart_mem_display_i (
        .clk_raw          (clk_raw),
        .rst_n            (rst_n),
        .uart_rx          (uart_rx),
        .switch_map       (switch_map),
        .seg_tube         (seg_tube),
        .seg_enable       (seg_enable),
        .uart_in_progress (uart_in_progress)
    );

    initial begin
        forever #2 clk_raw = ~clk_raw;
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic [3:0] decode_seg(input logic [7:0] pattern);
        logic [3:0] value;
        value = 4'h0;
        for (int v = 0; v < 16; v++)
            if (SEG_CODES[v] == pattern)
                value = 4'(v);
        return value;
    endfunction

    assert property (@(negedge clk_raw) $onehot(~seg_enable))
        else stop_with_error("seg_enable does not have exactly one digit active");

    assert property (@(negedge clk_raw) !rst_n |-> !uart_in_progress)
        else stop_with_error("uart_in_progress went high during reset");

    // rebuild the shown word and check the digit order
    always @(negedge clk_raw) begin
        prev_enable <= seg_enable;
        prev_pulse  <= uart_in_progress;
        if (uart_in_progress)
            pulse_count <= pulse_count + 1;
        if (!rst_n) begin
            assert (seg_enable == 8'hfe)
                else stop_with_error($sformatf("Fail reset_scan: expected fe, actual %h",
                    seg_enable));
        end else begin
            assert (seg_enable == prev_enable || seg_enable == {prev_enable[6:0], prev_enable[7]})
                else stop_with_error($sformatf("Fail scan_order: expected %h, actual %h",
                    {prev_enable[6:0], prev_enable[7]}, seg_enable));
        end
        assert (!(prev_pulse && uart_in_progress))
            else stop_with_error("uart_in_progress stayed high for more than one cycle");
        for (int d = 0; d < DIGITS; d++)
            if (!seg_enable[d])
                shown[d*4 +: 4] <= decode_seg(seg_tube);
    end

    // one 8N1 frame plus two idle bit times
    task automatic send_byte(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int b = 0; b < 10; b++) begin
            uart_rx = frame[b];
            repeat (CLKS_PER_BIT) @(negedge clk_raw);
        end
        uart_rx = 1'b1;
        repeat (2 * CLKS_PER_BIT) @(negedge clk_raw);
    endtask

    task automatic wait_for_pulses(input int target);
        int cycles;
        cycles = 0;
        while (pulse_count < target && cycles < 4 * CLKS_PER_BIT) begin
            @(negedge clk_raw);
            cycles++;
        end
        assert (pulse_count == target)
            else stop_with_error($sformatf("Fail write_pulse_count: expected %0d, actual %0d",
                target, pulse_count));
    endtask

    task automatic load_word(input word_t w);
        int target;
        target = pulse_count + 1;
        for (int i = 0; i < BYTES_PER_WORD; i++)
            send_byte(w[i*BYTE_W +: BYTE_W], 1'b1);
        wait_for_pulses(target);
    endtask

    task automatic check_display(input string name, input addr_t addr, input word_t expected);
        int cycles;
        cycles = 0;
        switch_map = 8'(addr);
        while (shown != expected && cycles < 2 * DIGITS * SCAN_CLKS + 8) begin
            @(negedge clk_raw);
            cycles++;
        end
        assert (shown == expected)
            else stop_with_error($sformatf("Fail %s: expected %h, actual %h",
                name, expected, shown));
    endtask

    initial begin
        word_t      expected_mem [RAM_DEPTH];
        word_t      w;
        logic [7:0] bad_byte;
        int         count_before;
        void'($urandom(32'h29543f6d));
        repeat (4) @(negedge clk_raw);
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk_raw);
            assert (!uart_in_progress)
                else stop_with_error("Fail reset_pulse: expected 0, actual 1");
        end

        expected_mem[0] = $urandom;
        load_word(expected_mem[0]);
        check_display("single_word", addr_t'(0), expected_mem[0]);

        for (int a = 1; a < 4; a++) begin
            expected_mem[a] = $urandom;
            load_word(expected_mem[a]);
        end
        for (int a = 1; a < 4; a++)
            check_display("sequential_addr", addr_t'(a), expected_mem[a]);
        check_display("first_word_kept", addr_t'(0), expected_mem[0]);

        // bad stop bit in the middle of the word at address 4
        w = $urandom;
        bad_byte = 8'($urandom);
        count_before = pulse_count;
        send_byte(w[7:0], 1'b1);
        send_byte(w[15:8], 1'b1);
        send_byte(bad_byte, 1'b0);
        send_byte(w[23:16], 1'b1);
        repeat (4 * CLKS_PER_BIT) @(negedge clk_raw);
        assert (pulse_count == count_before)
            else stop_with_error($sformatf("Fail three_bytes: expected %0d, actual %0d",
                count_before, pulse_count));
        send_byte(w[31:24], 1'b1);
        wait_for_pulses(count_before + 1);
        expected_mem[4] = w;
        check_display("framing_error", addr_t'(4), w);

        for (int a = 5; a < RAM_DEPTH; a++) begin
            expected_mem[a] = $urandom;
            load_word(expected_mem[a]);
        end
        w = $urandom;
        load_word(w);
        check_display("wrap_around", addr_t'(0), w);
        check_display("last_addr", addr_t'(RAM_DEPTH - 1), expected_mem[RAM_DEPTH-1]);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart_mem_display.f ====
rtl/uart_mem_pkg.sv
rtl/mem_port_if.sv
rtl/uart_byte_rx.sv
rtl/word_loader.sv
rtl/mem_arbiter.sv
rtl/data_ram.sv
rtl/hex_display.sv
rtl/uart_mem_display.sv
tb/tb_uart_mem_display.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_uart_mem_display
FILELIST  := uart_mem_display.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
